/* source/aluPkg.sv */
`default_nettype none

package aluPkg;

    // Datapath sizes
    localparam int DATA_W    = 32;
    localparam int NUM_REGS  = 16;
    localparam int REG_IDX_W = 4;
    localparam int FLAG_W    = 7;
    localparam int OP_W      = 4;
    localparam int ADDR_W    = 8;

    // Opcodes
    localparam logic [OP_W-1:0] OP_INVALID = 4'b0000;
    localparam logic [OP_W-1:0] OP_ADD     = 4'b0001;
    localparam logic [OP_W-1:0] OP_SUB     = 4'b0010;
    localparam logic [OP_W-1:0] OP_MUL     = 4'b0011;
    localparam logic [OP_W-1:0] OP_DIV     = 4'b0100;
    localparam logic [OP_W-1:0] OP_PASSA   = 4'b0101;
    localparam logic [OP_W-1:0] OP_PASSB   = 4'b0110;
    localparam logic [OP_W-1:0] OP_AND     = 4'b0111;
    localparam logic [OP_W-1:0] OP_OR      = 4'b1000;
    localparam logic [OP_W-1:0] OP_SHL     = 4'b1001;
    localparam logic [OP_W-1:0] OP_SAR     = 4'b1010;
    localparam logic [OP_W-1:0] OP_CMP     = 4'b1011;
    localparam logic [OP_W-1:0] OP_NOT     = 4'b1100;
    localparam logic [OP_W-1:0] OP_ZERO    = 4'b1101;
    localparam logic [OP_W-1:0] OP_COND    = 4'b1110;
    localparam logic [OP_W-1:0] OP_NOP     = 4'b1111;

    // Flag bit positions
    localparam int FLAG_ERROR     = 0;
    localparam int FLAG_COLLISION = 1; // Reserved
    localparam int FLAG_BETWEEN   = 2; // Reserved
    localparam int FLAG_BELOW     = 3;
    localparam int FLAG_EQUAL     = 4;
    localparam int FLAG_ABOVE     = 5;
    localparam int FLAG_OVERFLOW  = 6;

    // Instruction word fields
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 28;
    localparam int RD_MSB  = 27;
    localparam int RD_LSB  = 24;
    localparam int RS1_MSB = 23;
    localparam int RS1_LSB = 20;
    localparam int RS2_MSB = 19;
    localparam int RS2_LSB = 16;

    // Byte address map
    localparam logic [ADDR_W-1:0] ADDR_INSTR    = 8'h00;
    localparam logic [ADDR_W-1:0] ADDR_STATUS   = 8'h04;
    localparam logic [ADDR_W-1:0] ADDR_REG_BASE = 8'h40;
    localparam int                STATUS_ZERO_BIT = 8;

    // Condition operand of OP_COND
    typedef struct packed {
        logic [17:0]       reserved;
        logic [FLAG_W-1:0] expected; // Bits 13..7
        logic [FLAG_W-1:0] mask;     // Bits 6..0
    } condFields_t;

    typedef union packed {
        logic [DATA_W-1:0] data;
        condFields_t       cond;
    } condWord_u;

endpackage

`default_nettype wire

/* source/ALU.sv */
`timescale 1ns/1ps
`default_nettype none

module ALU (
    input  logic        [aluPkg::OP_W-1:0]   Operation,
    input  logic signed [aluPkg::DATA_W-1:0] data1,
    input  logic signed [aluPkg::DATA_W-1:0] data2,
    input  logic        [aluPkg::FLAG_W-1:0] RFlagsStored, // Flags held by execUnit
    output logic                             Zero,
    output logic signed [aluPkg::DATA_W-1:0] Result,
    output logic        [aluPkg::FLAG_W-1:0] RFlagsOut
);
    import aluPkg::*;

    logic signed [2*DATA_W-1:0] mulFull;
    logic        [FLAG_W-1:0]   rFlags;
    logic        [DATA_W-1:0]   shiftAmt;
    condWord_u                  condWord;

    always_comb begin
        Result        = '0;
        Zero          = 1'b0;
        rFlags        = '0;
        mulFull       = '0;
        condWord.data = data2;
        shiftAmt      = $unsigned(data1); // Shift count is unsigned

        case (Operation)
            OP_ADD: begin
                Result = data1 + data2;
                if ((data1[DATA_W-1] == data2[DATA_W-1]) &&
                    (Result[DATA_W-1] != data1[DATA_W-1]))
                    rFlags[FLAG_OVERFLOW] = 1'b1;
            end

            OP_SUB: begin
                Result = data1 - data2;
                if ((data1[DATA_W-1] != data2[DATA_W-1]) &&
                    (Result[DATA_W-1] != data1[DATA_W-1]))
                    rFlags[FLAG_OVERFLOW] = 1'b1;
            end

            OP_MUL: begin
                mulFull = data1 * data2; // Full 64-bit signed product
                Result  = mulFull[DATA_W-1:0];
                // Upper half must be pure sign extension of the low word
                if (mulFull[2*DATA_W-1:DATA_W-1] != {(DATA_W+1){mulFull[2*DATA_W-1]}}) begin
                    rFlags[FLAG_OVERFLOW] = 1'b1;
                    rFlags[FLAG_ERROR]    = 1'b1;
                end
            end

            OP_DIV: begin
                if (data2 == '0) begin
                    Result             = '0;
                    rFlags[FLAG_ERROR] = 1'b1; // Divide by zero
                end else begin
                    Result = data1 / data2; // Truncates toward zero
                end
            end

            OP_PASSA: Result = data1;

            OP_PASSB: Result = data2;

            OP_AND: Result = data1 & data2;

            OP_OR: Result = data1 | data2;

            OP_SHL: Result = data2 << shiftAmt;  // Zero past 31

            OP_SAR: Result = data2 >>> shiftAmt; // Sign fill past 31

            OP_CMP: begin
                if (data1 == data2)
                    rFlags[FLAG_EQUAL] = 1'b1;
                else if (data1 > data2)
                    rFlags[FLAG_ABOVE] = 1'b1;
                else
                    rFlags[FLAG_BELOW] = 1'b1;
            end

            OP_NOT: Result = ~data2;

            OP_ZERO: Zero = 1'b1;

            OP_COND: begin
                // Every masked stored flag must equal its expected bit
                Zero = ((RFlagsStored ^ condWord.cond.expected) & condWord.cond.mask) == '0;
            end

            OP_NOP: Zero = 1'b1;

            OP_INVALID: begin
                Zero               = 1'b1;
                rFlags[FLAG_ERROR] = 1'b1;
            end
        endcase

        RFlagsOut = rFlags;
    end

endmodule

`default_nettype wire

/* source/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [aluPkg::REG_IDX_W-1:0]   rs1Idx,
    input  logic [aluPkg::REG_IDX_W-1:0]   rs2Idx,
    input  logic                           exeWe,
    input  logic [aluPkg::REG_IDX_W-1:0]   exeIdx,
    input  logic [aluPkg::DATA_W-1:0]      exeWdata,
    input  logic                           hostWe,
    input  logic [aluPkg::REG_IDX_W-1:0]   hostIdx,
    input  logic [aluPkg::DATA_W-1:0]      hostWdata,
    output logic [aluPkg::DATA_W-1:0]      rs1Data,
    output logic [aluPkg::DATA_W-1:0]      rs2Data,
    output logic [aluPkg::DATA_W-1:0]      hostRdata
);
    import aluPkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (exeWe) begin
            regs[exeIdx] <= exeWdata; // Execute write has priority
        end else if (hostWe) begin
            regs[hostIdx] <= hostWdata;
        end
    end

    // Combinational read ports
    assign rs1Data   = regs[rs1Idx];
    assign rs2Data   = regs[rs2Idx];
    assign hostRdata = regs[hostIdx];

endmodule

`default_nettype wire

/* source/apbHost.sv */
`timescale 1ns/1ps
`default_nettype none

module apbHost (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           PSEL,
    input  logic                           PENABLE,
    input  logic                           PWRITE,
    input  logic [aluPkg::ADDR_W-1:0]      PADDR,
    input  logic [aluPkg::DATA_W-1:0]      PWDATA,
    output logic [aluPkg::DATA_W-1:0]      PRDATA,
    output logic                           PREADY,
    output logic                           PSLVERR,
    input  logic                           done,
    input  logic [aluPkg::DATA_W-1:0]      hostRdata,
    input  logic [aluPkg::FLAG_W-1:0]      storedFlags,
    input  logic                           zeroFlag,
    output logic                           issue,
    output logic [aluPkg::DATA_W-1:0]      instr,
    output logic                           hostWe,
    output logic [aluPkg::REG_IDX_W-1:0]   hostIdx,
    output logic [aluPkg::DATA_W-1:0]      hostWdata
);
    import aluPkg::*;

    localparam int REG_LSB = REG_IDX_W + 2; // Lowest bit above the register window

    logic              access;
    logic              isInstr;
    logic              isStatus;
    logic              isReg;
    logic              instrWr;
    logic              pending;
    logic [DATA_W-1:0] lastInstr;

    assign access   = PSEL & PENABLE; // Access phase
    assign isInstr  = (PADDR == ADDR_INSTR);
    assign isStatus = (PADDR == ADDR_STATUS);
    assign isReg    = (PADDR[ADDR_W-1:REG_LSB] == ADDR_REG_BASE[ADDR_W-1:REG_LSB]) &&
                      (PADDR[1:0] == 2'b00);

    // One instruction issue per transfer
    assign instrWr = access & PWRITE & isInstr;
    assign issue   = instrWr & ~pending;
    assign instr   = PWDATA;

    // Register writes finish in the first access cycle
    assign hostWe    = access & PWRITE & isReg;
    assign hostIdx   = PADDR[REG_LSB-1:2];
    assign hostWdata = PWDATA;

    // Only an instruction write waits until execUnit reports done
    assign PREADY  = ~instrWr | done;
    assign PSLVERR = access & (~(isInstr | isStatus | isReg) | (PWRITE & isStatus));

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (issue) begin
            pending <= 1'b1;
        end else if (done) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lastInstr <= '0;
        end else if (issue) begin
            lastInstr <= PWDATA; // Kept for readback
        end
    end

    always_comb begin
        PRDATA = '0;
        if (access && !PWRITE) begin
            if (isInstr) begin
                PRDATA = lastInstr;
            end else if (isStatus) begin
                PRDATA[FLAG_W-1:0]      = storedFlags;
                PRDATA[STATUS_ZERO_BIT] = zeroFlag;
            end else if (isReg) begin
                PRDATA = hostRdata;
            end
        end
    end

endmodule

`default_nettype wire

/* source/execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           issue,
    input  logic [aluPkg::DATA_W-1:0]      instr,
    input  logic [aluPkg::DATA_W-1:0]      result,
    input  logic                           zero,
    input  logic [aluPkg::FLAG_W-1:0]      flagsOut,
    output logic                           done,
    output logic [aluPkg::OP_W-1:0]        operation,
    output logic [aluPkg::REG_IDX_W-1:0]   rs1Idx,
    output logic [aluPkg::REG_IDX_W-1:0]   rs2Idx,
    output logic                           exeWe,
    output logic [aluPkg::REG_IDX_W-1:0]   exeIdx,
    output logic [aluPkg::DATA_W-1:0]      exeWdata,
    output logic [aluPkg::FLAG_W-1:0]      storedFlags,
    output logic                           zeroFlag
);
    import aluPkg::*;

    logic [DATA_W-1:0] instrQ;
    logic              busy;       // High in the execute cycle
    logic [FLAG_W-1:0] flagsQ;
    logic              zeroQ;
    logic              writesResult;
    logic              writesFlags;

    // Instruction captured on issue
    always_ff @(posedge clk) begin
        if (issue) begin
            instrQ <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            flagsQ <= '0;
            zeroQ  <= 1'b0;
        end else begin
            busy <= issue; // One execute cycle per issue
            if (busy) begin
                zeroQ <= zero; // Every instruction updates Zero
                if (writesFlags) begin
                    flagsQ <= flagsOut;
                end
            end
        end
    end

    // Fields of the latched word drive the ALU and register file
    assign operation = instrQ[OPC_MSB:OPC_LSB];
    assign exeIdx    = instrQ[RD_MSB:RD_LSB];
    assign rs1Idx    = instrQ[RS1_MSB:RS1_LSB];
    assign rs2Idx    = instrQ[RS2_MSB:RS2_LSB];

    // Compare and control operations leave the destination alone
    always_comb begin
        case (operation)
            OP_INVALID,
            OP_CMP,
            OP_ZERO,
            OP_COND,
            OP_NOP:  writesResult = 1'b0;
            default: writesResult = 1'b1;
        endcase
    end

    // ZERO, COND and NOP keep the stored flags
    assign writesFlags = (operation <= OP_NOT);

    assign exeWe       = busy & writesResult;
    assign exeWdata    = result;
    assign done        = busy;
    assign storedFlags = flagsQ;
    assign zeroFlag    = zeroQ;

endmodule

`default_nettype wire

/* source/aluCore.sv */
`timescale 1ns/1ps
`default_nettype none

module aluCore (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      PSEL,
    input  logic                      PENABLE,
    input  logic                      PWRITE,
    input  logic [aluPkg::ADDR_W-1:0] PADDR,
    input  logic [aluPkg::DATA_W-1:0] PWDATA,
    output logic [aluPkg::DATA_W-1:0] PRDATA,
    output logic                      PREADY,
    output logic                      PSLVERR
);
    import aluPkg::*;

    // Host side
    logic                 issue;
    logic [DATA_W-1:0]    instr;
    logic                 done;
    logic                 hostWe;
    logic [REG_IDX_W-1:0] hostIdx;
    logic [DATA_W-1:0]    hostWdata;
    logic [DATA_W-1:0]    hostRdata;

    // Execute side
    logic [OP_W-1:0]      operation;
    logic [REG_IDX_W-1:0] rs1Idx;
    logic [REG_IDX_W-1:0] rs2Idx;
    logic [DATA_W-1:0]    rs1Data;
    logic [DATA_W-1:0]    rs2Data;
    logic                 exeWe;
    logic [REG_IDX_W-1:0] exeIdx;
    logic [DATA_W-1:0]    exeWdata;
    logic [FLAG_W-1:0]    storedFlags;
    logic                 zeroFlag;
    logic [DATA_W-1:0]    aluResult;
    logic                 aluZero;
    logic [FLAG_W-1:0]    aluFlags;

    apbHost u_host (
        .clk         (clk),
        .rst         (rst),
        .PSEL        (PSEL),
        .PENABLE     (PENABLE),
        .PWRITE      (PWRITE),
        .PADDR       (PADDR),
        .PWDATA      (PWDATA),
        .PRDATA      (PRDATA),
        .PREADY      (PREADY),
        .PSLVERR     (PSLVERR),
        .done        (done),
        .hostRdata   (hostRdata),
        .storedFlags (storedFlags),
        .zeroFlag    (zeroFlag),
        .issue       (issue),
        .instr       (instr),
        .hostWe      (hostWe),
        .hostIdx     (hostIdx),
        .hostWdata   (hostWdata)
    );

    registerFile u_regFile (
        .clk       (clk),
        .rst       (rst),
        .rs1Idx    (rs1Idx),
        .rs2Idx    (rs2Idx),
        .exeWe     (exeWe),
        .exeIdx    (exeIdx),
        .exeWdata  (exeWdata),
        .hostWe    (hostWe),
        .hostIdx   (hostIdx),
        .hostWdata (hostWdata),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .hostRdata (hostRdata)
    );

    execUnit u_exec (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .instr       (instr),
        .result      (aluResult),
        .zero        (aluZero),
        .flagsOut    (aluFlags),
        .done        (done),
        .operation   (operation),
        .rs1Idx      (rs1Idx),
        .rs2Idx      (rs2Idx),
        .exeWe       (exeWe),
        .exeIdx      (exeIdx),
        .exeWdata    (exeWdata),
        .storedFlags (storedFlags),
        .zeroFlag    (zeroFlag)
    );

    ALU u_alu (
        .Operation    (operation),
        .data1        (rs1Data),
        .data2        (rs2Data),
        .RFlagsStored (storedFlags),
        .Zero         (aluZero),
        .Result       (aluResult),
        .RFlagsOut    (aluFlags)
    );

endmodule

`default_nettype wire

/* dv/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk
);
    localparam int HALF_PERIOD = 20; // 40 ns period

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* dv/aluCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module aluCoreTb;
    import aluPkg::*;

    localparam logic [31:0] SEED          = 32'h3738_cb62;
    localparam int          RESET_CYCLES  = 8;
    localparam int          READY_TIMEOUT = 16;
    localparam int          SETTLE        = 10; // Sample point after the falling edge

    logic              clk;
    logic              rst;
    logic              PSEL;
    logic              PENABLE;
    logic              PWRITE;
    logic [ADDR_W-1:0] PADDR;
    logic [DATA_W-1:0] PWDATA;
    logic [DATA_W-1:0] PRDATA;
    logic              PREADY;
    logic              PSLVERR;

    // Reference state
    logic [DATA_W-1:0] modelRegs [NUM_REGS];
    logic [FLAG_W-1:0] modelFlags;
    logic              modelZero;
    logic [DATA_W-1:0] modelInstr;

    int valueErrors    = 0;
    int protocolErrors = 0;

    tbClock u_clock (.clk(clk));

    aluCore u_aluCore (
        .clk     (clk),
        .rst     (rst),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWRITE  (PWRITE),
        .PADDR   (PADDR),
        .PWDATA  (PWDATA),
        .PRDATA  (PRDATA),
        .PREADY  (PREADY),
        .PSLVERR (PSLVERR)
    );

    // Instruction writes take one wait state
    assert property (@(posedge clk) disable iff (rst)
        $rose(PSEL && PENABLE) && PWRITE && (PADDR == ADDR_INSTR) |-> !PREADY ##1 PREADY)
    else begin
        protocolErrors++;
        $display("Instruction write at %0t did not finish after exactly one wait state", $time);
    end

    // Everything else completes at once
    assert property (@(posedge clk) disable iff (rst)
        $rose(PSEL && PENABLE) && !(PWRITE && (PADDR == ADDR_INSTR)) |-> PREADY)
    else begin
        protocolErrors++;
        $display("Access at %0t to address %h was stretched by the DUT", $time, PADDR);
    end

    task automatic checkValue(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        assert (got === exp) else begin
            valueErrors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic apbTransfer(input logic isWrite, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata,
                               output logic [DATA_W-1:0] rdata, output logic err);
        int waitCycles;
        waitCycles = 0;
        @(negedge clk);
        PSEL    = 1'b1; // Setup phase
        PENABLE = 1'b0;
        PWRITE  = isWrite;
        PADDR   = addr;
        PWDATA  = wdata;
        @(negedge clk);
        PENABLE = 1'b1;
        #(SETTLE);
        while (!PREADY && waitCycles < READY_TIMEOUT) begin
            @(negedge clk);
            #(SETTLE);
            waitCycles++;
        end
        if (PREADY) begin
            rdata = PRDATA;
            err   = PSLVERR;
            @(negedge clk); // Completing edge lies in between
            PSEL    = 1'b0;
            PENABLE = 1'b0;
        end else begin
            $display("PREADY stayed low for %0d cycles at address %h", waitCycles, addr);
            $display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
            $display("Test failures found");
            $finish;
        end
    endtask

    task automatic apbWrite(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic expErr);
        logic [DATA_W-1:0] unused;
        logic              err;
        apbTransfer(1'b1, addr, data, unused, err);
        checkValue($sformatf("PSLVERR@%h", addr), err, expErr);
    endtask

    task automatic apbRead(input logic [ADDR_W-1:0] addr, input logic expErr,
                           output logic [DATA_W-1:0] data);
        logic err;
        apbTransfer(1'b0, addr, '0, data, err);
        checkValue($sformatf("PSLVERR@%h", addr), err, expErr);
    endtask

    task automatic writeReg(input logic [REG_IDX_W-1:0] idx, input logic [DATA_W-1:0] data);
        apbWrite(ADDR_REG_BASE + {idx, 2'b00}, data, 1'b0);
        modelRegs[idx] = data;
    endtask

    task automatic readReg(input logic [REG_IDX_W-1:0] idx);
        logic [DATA_W-1:0] data;
        apbRead(ADDR_REG_BASE + {idx, 2'b00}, 1'b0, data);
        checkValue($sformatf("r%0d", idx), data, modelRegs[idx]);
    endtask

    task automatic checkStatus;
        logic [DATA_W-1:0] data;
        apbRead(ADDR_STATUS, 1'b0, data);
        checkValue("STATUS", data, {23'b0, modelZero, 1'b0, modelFlags});
    endtask

    function automatic logic fitsInt(input longint v);
        return v == longint'(int'(v));
    endfunction

    task automatic modelExecute(input logic [DATA_W-1:0] word);
        logic [OP_W-1:0]   op;
        int                a;
        int                b;
        longint            wide;
        logic [DATA_W-1:0] amt;
        logic [DATA_W-1:0] res;
        logic [FLAG_W-1:0] f;
        logic              z;
        logic              writes;
        condWord_u         cw;
        op      = word[OPC_MSB:OPC_LSB];
        a       = modelRegs[word[RS1_MSB:RS1_LSB]];
        b       = modelRegs[word[RS2_MSB:RS2_LSB]];
        amt     = a;
        cw.data = b;
        res     = '0;
        f       = '0;
        z       = 1'b0;
        writes  = 1'b1;
        case (op)
            OP_ADD, OP_SUB: begin
                wide = (op == OP_ADD) ? longint'(a) + longint'(b) : longint'(a) - longint'(b);
                res  = wide[DATA_W-1:0];
                f[FLAG_OVERFLOW] = !fitsInt(wide);
            end
            OP_MUL: begin
                wide = longint'(a) * longint'(b);
                res  = wide[DATA_W-1:0];
                f[FLAG_OVERFLOW] = !fitsInt(wide);
                f[FLAG_ERROR]    = !fitsInt(wide);
            end
            OP_DIV: begin
                if (b == 0) begin
                    f[FLAG_ERROR] = 1'b1;
                end else begin
                    wide = longint'(a) / longint'(b);
                    res  = wide[DATA_W-1:0];
                end
            end
            OP_PASSA: res = a;
            OP_PASSB: res = b;
            OP_AND:   res = a & b;
            OP_OR:    res = a | b;
            OP_SHL: begin
                if (amt < 32) res = b << amt;
            end
            OP_SAR: begin
                if (amt < 32) res = b >>> amt;
                else res = {DATA_W{b[DATA_W-1]}};
            end
            OP_CMP: begin
                writes = 1'b0;
                if (a == b) f[FLAG_EQUAL] = 1'b1;
                else if (a > b) f[FLAG_ABOVE] = 1'b1;
                else f[FLAG_BELOW] = 1'b1;
            end
            OP_NOT: res = ~b;
            OP_COND: begin
                writes = 1'b0;
                z      = 1'b1;
                for (int i = 0; i < FLAG_W; i++) begin
                    if (cw.cond.mask[i] && (cw.cond.expected[i] != modelFlags[i])) z = 1'b0;
                end
            end
            OP_INVALID: begin
                writes        = 1'b0;
                z             = 1'b1;
                f[FLAG_ERROR] = 1'b1;
            end
            default: begin // ZERO and NOP
                writes = 1'b0;
                z      = 1'b1;
            end
        endcase
        if (writes) modelRegs[word[RD_MSB:RD_LSB]] = res;
        if (!(op inside {OP_ZERO, OP_COND, OP_NOP})) modelFlags = f;
        modelZero  = z;
        modelInstr = word;
    endtask

    // Load two operands, issue, then check destination and status
    task automatic runOp(input logic [OP_W-1:0] op, input logic [DATA_W-1:0] a,
                         input logic [DATA_W-1:0] b);
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [DATA_W-1:0]    word;
        rs1 = $urandom_range(NUM_REGS - 1);
        rs2 = rs1 + 1 + $urandom_range(NUM_REGS - 2); // Never equal to rs1
        rd  = $urandom_range(NUM_REGS - 1);
        writeReg(rs1, a);
        writeReg(rs2, b);
        word = {op, rd, rs1, rs2, 16'($urandom)}; // Low bits are don't care
        apbWrite(ADDR_INSTR, word, 1'b0);
        modelExecute(word);
        readReg(rd);
        checkStatus();
    endtask

    initial begin
        logic [DATA_W-1:0] data;
        logic [OP_W-1:0]   arithOps [4];
        logic [OP_W-1:0]   logicOps [7];
        logic [DATA_W-1:0] shiftAmts [7];
        condWord_u         cw;
        arithOps  = '{OP_ADD, OP_SUB, OP_MUL, OP_DIV};
        logicOps  = '{OP_AND, OP_OR, OP_NOT, OP_PASSA, OP_PASSB, OP_SHL, OP_SAR};
        shiftAmts = '{0, 1, 17, 31, 32, 45, 32'hffff_ffff};
        rst     = 1'b1;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = '0;
        PWDATA  = '0;
        void'($urandom(SEED));
        for (int i = 0; i < NUM_REGS; i++) modelRegs[i] = '0;
        modelFlags = '0;
        modelZero  = 1'b0;
        modelInstr = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Reset values and plain register access
        checkStatus();
        for (int i = 0; i < 4; i++) readReg($urandom_range(NUM_REGS - 1));
        for (int i = 0; i < NUM_REGS; i++) writeReg(i, $urandom);
        for (int i = 0; i < NUM_REGS; i++) readReg(i);
        apbWrite(8'h08, $urandom, 1'b1);
        apbWrite(8'h42, $urandom, 1'b1); // Misaligned
        apbWrite(ADDR_STATUS, '1, 1'b1);
        apbRead(8'h80, 1'b1, data);
        checkStatus();
        for (int i = 0; i < NUM_REGS; i++) readReg(i);

        // Random arithmetic then corner pairs
        for (int i = 0; i < 8; i++) begin
            foreach (arithOps[k]) runOp(arithOps[k], $urandom, $urandom);
        end
        runOp(OP_ADD, 32'h7fff_ffff, 32'h1);
        runOp(OP_ADD, 32'h8000_0000, 32'hffff_ffff);
        runOp(OP_SUB, 32'h8000_0000, 32'h1);
        runOp(OP_SUB, 32'h7fff_fff0, 32'hffff_fff0);
        runOp(OP_MUL, 32'h0001_0000, 32'h0001_0000);
        runOp(OP_MUL, 32'hffff_fffd, 32'h0000_0007);
        runOp(OP_MUL, 32'h0000_b504, 32'h0000_b504);
        runOp(OP_DIV, $urandom, 32'h0);
        runOp(OP_DIV, 32'hffff_fff9, 32'h2);
        runOp(OP_DIV, 32'h0000_0064, 32'hffff_fff9);

        // Logic, pass and shifts after an overflow so clearing shows
        runOp(OP_ADD, 32'h7fff_ffff, 32'h7fff_ffff);
        for (int i = 0; i < 4; i++) begin
            foreach (logicOps[k]) runOp(logicOps[k], $urandom, $urandom);
        end
        foreach (shiftAmts[k]) begin
            runOp(OP_SHL, shiftAmts[k], $urandom);
            runOp(OP_SAR, shiftAmts[k], 32'h8000_0000 | $urandom);
            runOp(OP_SAR, shiftAmts[k], 32'h7fff_ffff & $urandom);
        end

        // Signed compare
        runOp(OP_CMP, 32'h1234_5678, 32'h1234_5678);
        runOp(OP_CMP, 32'hffff_fffe, 32'hffff_fff0);
        runOp(OP_CMP, 32'h8000_0000, 32'h0000_0001);
        runOp(OP_CMP, 32'h0000_0005, 32'hffff_ffff); // Above after BELOW

        // Condition words against the stored ABOVE flag
        cw.data          = $urandom;
        cw.cond.mask     = (1 << FLAG_ABOVE) | (1 << FLAG_EQUAL);
        cw.cond.expected = 1 << FLAG_ABOVE;
        runOp(OP_COND, $urandom, cw.data);
        cw.cond.expected = 1 << FLAG_EQUAL;
        runOp(OP_COND, $urandom, cw.data);
        cw.cond.mask = '0;
        runOp(OP_COND, $urandom, cw.data);

        // Control operations keep flags and registers
        runOp(OP_INVALID, $urandom, $urandom);
        runOp(OP_ZERO, $urandom, $urandom);
        runOp(OP_CMP, 32'h3, 32'h9);
        runOp(OP_NOP, $urandom, $urandom);
        runOp(OP_ZERO, $urandom, $urandom);
        for (int i = 0; i < NUM_REGS; i++) readReg(i);
        apbRead(ADDR_INSTR, 1'b0, data);
        checkValue("INSTR", data, modelInstr);

        @(negedge clk);
        $display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
source/aluPkg.sv
source/ALU.sv
source/registerFile.sv
source/apbHost.sv
source/execUnit.sv
source/aluCore.sv
dv/tbClock.sv
dv/aluCoreTb.sv
